//--- hw/exec_consts.svh
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// ============================================================
// Execute stage widths and depths
// ============================================================

// Data word width
`define EXEC_XLEN 32

// Physical register tag and ROB index widths
`define EXEC_PREG_BITS 6
`define EXEC_ROB_BITS 5

// Multiplier latency in cycles, one register per stage
`define EXEC_MUL_STAGES 3

// Writeback bus lanes: ALU, multiplier, branch
`define EXEC_WB_LANES 3

`endif

//--- hw/exec_pkg.sv
`default_nettype none

`include "exec_consts.svh"

package exec_pkg;

  // ============================================================
  // Operation encodings
  // ============================================================

  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    SLL  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    SLT  = 4'd8,
    SLTU = 4'd9
  } alu_op_e;

  // Same order as the RV32M funct3 field
  typedef enum logic [1:0] {
    MUL    = 2'd0,
    MULH   = 2'd1,
    MULHSU = 2'd2,
    MULHU  = 2'd3
  } mul_op_e;

  // Branch funct3 values, JUMP takes the unused 010 slot
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    JUMP = 3'b010,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } br_cond_e;

  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_LOAD  = 2'd1,
    MEM_STORE = 2'd2
  } mem_op_e;

  // ============================================================
  // Packets
  // ============================================================

  typedef struct packed {
    logic                        valid;
    alu_op_e                     alu_op;
    mul_op_e                     mul_op;
    br_cond_e                    br_cond;
    mem_op_e                     mem_op;
    logic [`EXEC_XLEN-1:0]       src1_val;
    logic [`EXEC_XLEN-1:0]       src2_val;
    logic [11:0]                 imm;
    logic [`EXEC_XLEN-1:0]       pc;
    logic                        pred_taken;
    logic [`EXEC_PREG_BITS-1:0]  dest_tag;
    logic [`EXEC_ROB_BITS-1:0]   rob_idx;
  } issue_packet_t;

  typedef struct packed {
    logic                        valid;
    logic [`EXEC_XLEN-1:0]       value;
    logic [`EXEC_PREG_BITS-1:0]  dest_prf;
    logic [`EXEC_ROB_BITS-1:0]   rob_idx;
    logic                        mispred;
    logic                        taken;
  } wb_resp_t;

  typedef struct packed {
    logic                        valid;
    logic                        is_store;
    logic [`EXEC_XLEN-1:0]       addr;
    logic [`EXEC_XLEN-1:0]       store_data;
    logic [`EXEC_PREG_BITS-1:0]  dest_prf;
    logic [`EXEC_ROB_BITS-1:0]   rob_idx;
  } lsq_req_t;

endpackage

`default_nettype wire

//--- hw/alu_fu.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module alu_fu (
  input  exec_pkg::issue_packet_t req_i,
  output exec_pkg::wb_resp_t      resp_o
);

  logic [`EXEC_XLEN-1:0] src1;
  logic [`EXEC_XLEN-1:0] src2;
  logic [4:0]            shamt;
  logic [`EXEC_XLEN-1:0] result;

  assign src1  = req_i.src1_val;
  assign src2  = req_i.src2_val;
  // Only the low five bits count for RV32 shifts
  assign shamt = req_i.src2_val[4:0];

  always_comb begin
    case (req_i.alu_op)
      exec_pkg::ADD:  result = src1 + src2;
      exec_pkg::SUB:  result = src1 - src2;
      exec_pkg::AND:  result = src1 & src2;
      exec_pkg::OR:   result = src1 | src2;
      exec_pkg::XOR:  result = src1 ^ src2;
      exec_pkg::SLL:  result = src1 << shamt;
      exec_pkg::SRL:  result = src1 >> shamt;
      exec_pkg::SRA:  result = $unsigned($signed(src1) >>> shamt);
      exec_pkg::SLT:  result = {{(`EXEC_XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
      exec_pkg::SLTU: result = {{(`EXEC_XLEN-1){1'b0}}, src1 < src2};
      default:        result = '0;
    endcase
  end

  always_comb begin
    resp_o.valid    = req_i.valid;
    resp_o.value    = result;
    resp_o.dest_prf = req_i.dest_tag;
    resp_o.rob_idx  = req_i.rob_idx;
    resp_o.mispred  = 1'b0;
    resp_o.taken    = 1'b0;
  end

  // Issue must never hand the ALU an undefined opcode
  always_comb begin
    if (req_i.valid) begin
      assert (req_i.alu_op inside {[exec_pkg::ADD : exec_pkg::SLTU]})
        else $error("alu_fu: undefined opcode %0d", req_i.alu_op);
    end
  end

endmodule

`default_nettype wire

//--- hw/mul_fu.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module mul_fu (
  input  logic                    clock,
  input  logic                    reset,
  input  exec_pkg::issue_packet_t req_i,
  output exec_pkg::wb_resp_t      resp_o
);

  // Payload that travels down the pipe beside its valid bit
  typedef struct packed {
    exec_pkg::mul_op_e           op;
    logic [2*`EXEC_XLEN-1:0]     product;
    logic [`EXEC_PREG_BITS-1:0]  dest_tag;
    logic [`EXEC_ROB_BITS-1:0]   rob_idx;
  } mul_stage_t;

  logic                                 a_signed;
  logic                                 b_signed;
  logic [2*`EXEC_XLEN-1:0]              op_a_ext;
  logic [2*`EXEC_XLEN-1:0]              op_b_ext;
  mul_stage_t                           stage_in;
  mul_stage_t [`EXEC_MUL_STAGES-1:0]    stage_q;
  logic [`EXEC_MUL_STAGES-1:0]          valid_q;
  mul_stage_t                           out_stage;

  // ============================================================
  // Operand extension and product
  // ============================================================

  // Low word is the same for any extension, MUL shares the signed path
  assign a_signed = (req_i.mul_op != exec_pkg::MULHU);
  assign b_signed = (req_i.mul_op == exec_pkg::MULH) || (req_i.mul_op == exec_pkg::MUL);

  assign op_a_ext = {{`EXEC_XLEN{a_signed & req_i.src1_val[`EXEC_XLEN-1]}}, req_i.src1_val};
  assign op_b_ext = {{`EXEC_XLEN{b_signed & req_i.src2_val[`EXEC_XLEN-1]}}, req_i.src2_val};

  always_comb begin
    stage_in.op       = req_i.mul_op;
    stage_in.product  = op_a_ext * op_b_ext;
    stage_in.dest_tag = req_i.dest_tag;
    stage_in.rob_idx  = req_i.rob_idx;
  end

  // ============================================================
  // Pipeline registers
  // ============================================================

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[`EXEC_MUL_STAGES-2:0], req_i.valid};
    end
  end

  // Product and tags shift together so each result keeps its own tags
  always_ff @(posedge clock) begin
    stage_q[0] <= stage_in;
    for (int i = 1; i < `EXEC_MUL_STAGES; i++) begin
      stage_q[i] <= stage_q[i-1];
    end
  end

  // Final word select
  assign out_stage = stage_q[`EXEC_MUL_STAGES-1];

  always_comb begin
    resp_o.valid    = valid_q[`EXEC_MUL_STAGES-1];
    resp_o.value    = (out_stage.op == exec_pkg::MUL) ?
                      out_stage.product[`EXEC_XLEN-1:0] :
                      out_stage.product[2*`EXEC_XLEN-1:`EXEC_XLEN];
    resp_o.dest_prf = out_stage.dest_tag;
    resp_o.rob_idx  = out_stage.rob_idx;
    resp_o.mispred  = 1'b0;
    resp_o.taken    = 1'b0;
  end

  // Output valid follows the request valid of three edges back
  assert property (@(posedge clock) disable iff (reset)
    (!$past(reset, 1) && !$past(reset, 2) && !$past(reset, 3))
      |-> (resp_o.valid == $past(req_i.valid, `EXEC_MUL_STAGES)));

endmodule

`default_nettype wire

//--- hw/ls_fu.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module ls_fu (
  input  exec_pkg::issue_packet_t req_i,
  output exec_pkg::lsq_req_t      lsq_o
);

  logic [`EXEC_XLEN-1:0] imm_ext;
  logic                  is_load;
  logic                  is_store;

  // Sign extended 12 bit offset
  assign imm_ext  = {{(`EXEC_XLEN-12){req_i.imm[11]}}, req_i.imm};

  assign is_load  = (req_i.mem_op == exec_pkg::MEM_LOAD);
  assign is_store = (req_i.mem_op == exec_pkg::MEM_STORE);

  always_comb begin
    lsq_o.valid      = req_i.valid && (is_load || is_store);
    lsq_o.is_store   = is_store;
    lsq_o.addr       = req_i.src1_val + imm_ext;
    lsq_o.rob_idx    = req_i.rob_idx;
    // Stores write no register
    if (is_store) begin
      lsq_o.store_data = req_i.src2_val;
      lsq_o.dest_prf   = '0;
    end else begin
      lsq_o.store_data = '0;
      lsq_o.dest_prf   = req_i.dest_tag;
    end
  end

  // Issue only routes memory operations to this unit
  always_comb begin
    if (req_i.valid) begin
      assert (req_i.mem_op != exec_pkg::MEM_NONE)
        else $error("ls_fu: valid request without a memory operation");
    end
  end

endmodule

`default_nettype wire

//--- hw/branch_fu.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module branch_fu (
  input  exec_pkg::issue_packet_t req_i,
  output exec_pkg::wb_resp_t      resp_o
);

  exec_pkg::issue_packet_t link_req;
  exec_pkg::wb_resp_t      link_resp;
  logic [`EXEC_XLEN-1:0]   src1;
  logic [`EXEC_XLEN-1:0]   src2;
  logic                    take;

  // ============================================================
  // Link value, pc + 4 through a private ALU
  // ============================================================

  always_comb begin
    link_req          = req_i;
    link_req.alu_op   = exec_pkg::ADD;
    link_req.src1_val = req_i.pc;
    link_req.src2_val = `EXEC_XLEN'd4;
  end

  alu_fu u_link_alu (
    .req_i  (link_req),
    .resp_o (link_resp)
  );

  // ============================================================
  // Condition evaluation
  // ============================================================

  assign src1 = req_i.src1_val;
  assign src2 = req_i.src2_val;

  always_comb begin
    case (req_i.br_cond)
      exec_pkg::BEQ:  take = (src1 == src2);
      exec_pkg::BNE:  take = (src1 != src2);
      exec_pkg::BLT:  take = ($signed(src1) < $signed(src2));
      exec_pkg::BGE:  take = ($signed(src1) >= $signed(src2));
      exec_pkg::BLTU: take = (src1 < src2);
      exec_pkg::BGEU: take = (src1 >= src2);
      exec_pkg::JUMP: take = 1'b1;
      default:        take = 1'b0;
    endcase
  end

  // Tags come through the link ALU unchanged
  always_comb begin
    resp_o.valid    = link_resp.valid;
    resp_o.value    = link_resp.value;
    resp_o.dest_prf = link_resp.dest_prf;
    resp_o.rob_idx  = link_resp.rob_idx;
    resp_o.taken    = take;
    // Predictor guessed the wrong direction
    resp_o.mispred  = take ^ req_i.pred_taken;
  end

endmodule

`default_nettype wire

//--- hw/exec_units.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module exec_units (
  input  logic                                         clock,
  input  logic                                         reset,

  // One request port per unit
  input  exec_pkg::issue_packet_t                      alu_req_i,
  input  exec_pkg::issue_packet_t                      mul_req_i,
  input  exec_pkg::issue_packet_t                      ls_req_i,
  input  exec_pkg::issue_packet_t                      br_req_i,

  // Writeback bus and LSQ port
  output exec_pkg::wb_resp_t [`EXEC_WB_LANES-1:0]      wb_o,
  output exec_pkg::lsq_req_t                           lsq_o
);

  // Writeback lane assignment
  localparam int LANE_ALU = 0;
  localparam int LANE_MUL = 1;
  localparam int LANE_BR  = 2;

  exec_pkg::wb_resp_t alu_resp;
  exec_pkg::wb_resp_t mul_resp;
  exec_pkg::wb_resp_t br_resp;

  // ============================================================
  // Functional units
  // ============================================================

  alu_fu u_alu (
    .req_i  (alu_req_i),
    .resp_o (alu_resp)
  );

  mul_fu u_mul (
    .clock  (clock),
    .reset  (reset),
    .req_i  (mul_req_i),
    .resp_o (mul_resp)
  );

  // Address packets go only to the LSQ, never on writeback
  ls_fu u_ls (
    .req_i  (ls_req_i),
    .lsq_o  (lsq_o)
  );

  branch_fu u_br (
    .req_i  (br_req_i),
    .resp_o (br_resp)
  );

  // ============================================================
  // Writeback routing
  // ============================================================

  assign wb_o[LANE_ALU] = alu_resp;
  assign wb_o[LANE_MUL] = mul_resp;
  assign wb_o[LANE_BR]  = br_resp;

endmodule

`default_nettype wire

//--- bench/exec_units_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module exec_units_tb;

  typedef logic [`EXEC_XLEN-1:0] word_t;

  localparam int    CLK_PERIOD   = 8;
  localparam int    RESET_CYCLES = 16;
  localparam int    NUM_ROWS     = 22;
  localparam int    RAND_FIRST   = 15;
  localparam int    RAND_LAST    = 20;
  localparam word_t SIGN_BIT     = 32'h8000_0000;

  // One table row with a request per unit and what each output should show
  typedef struct packed {
    exec_pkg::issue_packet_t alu;
    exec_pkg::issue_packet_t mul;
    exec_pkg::issue_packet_t ls;
    exec_pkg::issue_packet_t br;
    exec_pkg::wb_resp_t      exp_alu;
    exec_pkg::wb_resp_t      exp_mul;
    exec_pkg::wb_resp_t      exp_br;
    exec_pkg::lsq_req_t      exp_lsq;
  } row_t;

  typedef struct {
    int                 due;
    exec_pkg::wb_resp_t resp;
  } mul_exp_t;

  logic                                    clock;
  logic                                    reset;
  exec_pkg::issue_packet_t                 alu_req;
  exec_pkg::issue_packet_t                 mul_req;
  exec_pkg::issue_packet_t                 ls_req;
  exec_pkg::issue_packet_t                 br_req;
  exec_pkg::wb_resp_t [`EXEC_WB_LANES-1:0] wb;
  exec_pkg::lsq_req_t                      lsq;

  row_t     rows [NUM_ROWS];
  row_t     cur;
  mul_exp_t mul_q [$];
  int       seed;
  int       errors;
  int       checks;

  exec_units dut (
    .clock     (clock),
    .reset     (reset),
    .alu_req_i (alu_req),
    .mul_req_i (mul_req),
    .ls_req_i  (ls_req),
    .br_req_i  (br_req),
    .wb_o      (wb),
    .lsq_o     (lsq)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // ============================================================
  // Reference models
  // ============================================================

  function automatic word_t alu_model(exec_pkg::alu_op_e op, word_t a, word_t b);
    logic [63:0] wide;
    wide = {{32{a[31]}}, a} >> b[4:0];
    case (op)
      exec_pkg::ADD:  return a + b;
      exec_pkg::SUB:  return a + ~b + 32'd1;
      exec_pkg::AND:  return a & b;
      exec_pkg::OR:   return a | b;
      exec_pkg::XOR:  return a ^ b;
      exec_pkg::SLL:  return a << b[4:0];
      exec_pkg::SRL:  return a >> b[4:0];
      exec_pkg::SRA:  return wide[31:0];
      // Flipping the sign bit turns a signed compare into an unsigned one
      exec_pkg::SLT:  return {31'd0, (a ^ SIGN_BIT) < (b ^ SIGN_BIT)};
      exec_pkg::SLTU: return {31'd0, a < b};
      default:        return 32'd0;
    endcase
  endfunction

  function automatic word_t mul_model(exec_pkg::mul_op_e op, word_t a, word_t b);
    longint sa;
    longint sb;
    longint ua;
    longint ub;
    longint prod;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    ua = longint'({32'd0, a});
    ub = longint'({32'd0, b});
    case (op)
      exec_pkg::MULHSU: prod = sa * ub;
      exec_pkg::MULHU:  prod = ua * ub;
      default:          prod = sa * sb;
    endcase
    return (op == exec_pkg::MUL) ? prod[31:0] : prod[63:32];
  endfunction

  function automatic logic taken_model(exec_pkg::br_cond_e c, word_t a, word_t b);
    logic lt_s;
    lt_s = (a ^ SIGN_BIT) < (b ^ SIGN_BIT);
    case (c)
      exec_pkg::BEQ:  return a == b;
      exec_pkg::BNE:  return a != b;
      exec_pkg::BLT:  return lt_s;
      exec_pkg::BGE:  return !lt_s;
      exec_pkg::BLTU: return a < b;
      exec_pkg::BGEU: return !(a < b);
      exec_pkg::JUMP: return 1'b1;
      default:        return 1'b0;
    endcase
  endfunction

  // ============================================================
  // Table construction
  // ============================================================

  function automatic exec_pkg::issue_packet_t make_req(int r, int tag_base, word_t a, word_t b);
    exec_pkg::issue_packet_t p;
    p          = '0;
    p.valid    = 1'b1;
    p.src1_val = a;
    p.src2_val = b;
    p.dest_tag = `EXEC_PREG_BITS'(r + tag_base);
    p.rob_idx  = `EXEC_ROB_BITS'(r + tag_base);
    return p;
  endfunction

  function automatic exec_pkg::wb_resp_t make_wb(exec_pkg::issue_packet_t p, word_t value);
    exec_pkg::wb_resp_t w;
    w          = '0;
    w.valid    = 1'b1;
    w.value    = value;
    w.dest_prf = p.dest_tag;
    w.rob_idx  = p.rob_idx;
    return w;
  endfunction

  task automatic set_alu(int r, exec_pkg::alu_op_e op, word_t a, word_t b);
    rows[r].alu        = make_req(r, 0, a, b);
    rows[r].alu.alu_op = op;
    rows[r].exp_alu    = make_wb(rows[r].alu, alu_model(op, a, b));
  endtask

  task automatic set_mul(int r, exec_pkg::mul_op_e op, word_t a, word_t b);
    rows[r].mul        = make_req(r, 21, a, b);
    rows[r].mul.mul_op = op;
    rows[r].exp_mul    = make_wb(rows[r].mul, mul_model(op, a, b));
  endtask

  task automatic set_ls(int r, exec_pkg::mem_op_e op, word_t base, logic [11:0] imm, word_t data);
    exec_pkg::lsq_req_t e;
    rows[r].ls        = make_req(r, 10, base, data);
    rows[r].ls.mem_op = op;
    rows[r].ls.imm    = imm;
    e            = '0;
    e.valid      = 1'b1;
    e.is_store   = (op == exec_pkg::MEM_STORE);
    e.addr       = base + {{20{imm[11]}}, imm};
    e.store_data = e.is_store ? data : '0;
    e.dest_prf   = e.is_store ? '0 : rows[r].ls.dest_tag;
    e.rob_idx    = rows[r].ls.rob_idx;
    rows[r].exp_lsq = e;
  endtask

  task automatic set_br(int r, exec_pkg::br_cond_e c, word_t a, word_t b, word_t pc, logic pred);
    logic taken;
    rows[r].br            = make_req(r, 42, a, b);
    rows[r].br.br_cond    = c;
    rows[r].br.pc         = pc;
    rows[r].br.pred_taken = pred;
    taken                 = taken_model(c, a, b);
    rows[r].exp_br         = make_wb(rows[r].br, pc + 32'd4);
    rows[r].exp_br.taken   = taken;
    rows[r].exp_br.mispred = (taken != pred);
  endtask

  task automatic set_random(int r);
    word_t      a;
    word_t      b;
    word_t      c;
    word_t      d;
    logic [2:0] cond;
    a    = $random(seed);
    b    = $random(seed);
    c    = $random(seed);
    d    = $random(seed);
    cond = 3'($random(seed));
    // 011 is no branch condition
    if (cond == 3'b011) begin
      cond = 3'b010;
    end
    set_alu(r, exec_pkg::alu_op_e'(4'($unsigned($random(seed)) % 10)), a, b);
    set_mul(r, exec_pkg::mul_op_e'(2'($random(seed))), c, d);
    set_ls(r, d[0] ? exec_pkg::MEM_STORE : exec_pkg::MEM_LOAD, c, d[31:20], a);
    set_br(r, exec_pkg::br_cond_e'(cond), a, cond[0] ? a : b, {c[31:2], 2'b00}, d[1]);
  endtask

  task automatic build_table();
    for (int i = 0; i < NUM_ROWS; i++) begin
      rows[i] = '0;
    end
    set_alu(0, exec_pkg::ADD, 32'h0000_0007, 32'h0000_0005);
    set_alu(1, exec_pkg::SUB, 32'h0000_0003, 32'h0000_0005);
    set_alu(2, exec_pkg::AND, 32'hF0F0_1234, 32'h0FF0_FF00);
    set_alu(3, exec_pkg::OR, 32'hF000_0001, 32'h0000_1230);
    set_alu(4, exec_pkg::XOR, 32'hAAAA_5555, 32'hFFFF_0000);
    set_alu(5, exec_pkg::SLL, 32'h8000_0003, 32'h0000_0021);
    set_alu(6, exec_pkg::SRL, 32'h8000_0000, 32'h0000_0004);
    set_alu(7, exec_pkg::SRA, 32'h8000_0010, 32'h0000_0004);
    set_alu(8, exec_pkg::SLT, 32'hFFFF_FFFF, 32'h0000_0001);
    set_alu(9, exec_pkg::SLTU, 32'hFFFF_FFFF, 32'h0000_0001);
    set_alu(10, exec_pkg::SLT, 32'h0000_0005, 32'hFFFF_FFFD);
    set_alu(11, exec_pkg::SLTU, 32'h0000_0001, 32'hFFFF_FFFF);
    set_alu(12, exec_pkg::SRA, 32'hFFFF_FF00, 32'h0000_001F);
    // Back to back multiplies and one more after a gap
    set_mul(0, exec_pkg::MUL, 32'h0000_1234, 32'hFFFF_FFFE);
    set_mul(1, exec_pkg::MULH, 32'hFFFF_FFFE, 32'h0000_0003);
    set_mul(2, exec_pkg::MULHSU, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
    set_mul(3, exec_pkg::MULHU, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
    set_mul(6, exec_pkg::MULH, 32'h8000_0000, 32'h8000_0000);
    set_ls(1, exec_pkg::MEM_LOAD, 32'h0000_1000, 12'h010, 32'h0);
    set_ls(2, exec_pkg::MEM_LOAD, 32'h0000_1000, 12'hFFC, 32'h0);
    set_ls(3, exec_pkg::MEM_STORE, 32'h2000_0000, 12'h7FF, 32'hDEAD_BEEF);
    set_ls(4, exec_pkg::MEM_STORE, 32'h0000_0100, 12'h800, 32'h1234_5678);
    set_ls(5, exec_pkg::MEM_LOAD, 32'h0000_0000, 12'hFFF, 32'h0);
    set_br(0, exec_pkg::BEQ, 32'd5, 32'd5, 32'h0000_0100, 1'b1);
    set_br(1, exec_pkg::BNE, 32'd5, 32'd5, 32'h0000_0104, 1'b1);
    set_br(2, exec_pkg::BLT, 32'hFFFF_FFFF, 32'd1, 32'h0000_0108, 1'b0);
    set_br(3, exec_pkg::BGE, 32'hFFFF_FFFF, 32'd1, 32'h0000_010C, 1'b0);
    set_br(4, exec_pkg::BLTU, 32'hFFFF_FFFF, 32'd1, 32'h0000_0110, 1'b1);
    set_br(5, exec_pkg::BGEU, 32'hFFFF_FFFF, 32'd1, 32'h0000_0114, 1'b1);
    set_br(6, exec_pkg::JUMP, 32'd0, 32'd0, 32'h0000_0118, 1'b0);
    set_br(7, exec_pkg::JUMP, 32'd0, 32'd0, 32'hFFFF_FFFC, 1'b1);
    set_br(8, exec_pkg::BEQ, 32'd1, 32'd2, 32'h0000_0120, 1'b0);
    set_br(9, exec_pkg::BGE, 32'd7, 32'd7, 32'h0000_0124, 1'b1);
    // Rows 13, 14 and 21 stay idle
    for (int r = RAND_FIRST; r <= RAND_LAST; r++) begin
      set_random(r);
    end
  endtask

  // ============================================================
  // Checks
  // ============================================================

  task automatic check_wb(string name, exec_pkg::wb_resp_t got, exec_pkg::wb_resp_t want);
    checks++;
    if (want.valid) begin
      assert (got === want) else begin
        errors++;
        $display("Error %s: got %h expected %h", name, got, want);
      end
    end else begin
      assert (got.valid === 1'b0) else begin
        errors++;
        $display("Error %s.valid: got %h expected 0", name, got.valid);
      end
    end
  endtask

  task automatic check_lsq(exec_pkg::lsq_req_t got, exec_pkg::lsq_req_t want);
    checks++;
    // Store data means nothing for a load
    if (!want.is_store) begin
      got.store_data = '0;
    end
    if (want.valid) begin
      assert (got === want) else begin
        errors++;
        $display("Error lsq_o: got %h expected %h", got, want);
      end
    end else begin
      assert (got.valid === 1'b0) else begin
        errors++;
        $display("Error lsq_o.valid: got %h expected 0", got.valid);
      end
    end
  endtask

  task automatic check_mul(int cyc);
    mul_exp_t e;
    if (mul_q.size() > 0 && mul_q[0].due == cyc) begin
      e = mul_q.pop_front();
    end else begin
      e.resp = '0;
    end
    check_wb("wb_o[1]", wb[1], e.resp);
  endtask

  initial begin
    alu_req = '0;
    mul_req = '0;
    ls_req  = '0;
    br_req  = '0;
    reset   = 1'b1;
    errors  = 0;
    checks  = 0;
    seed    = 83741;
    build_table();
    repeat (RESET_CYCLES - 1) @(posedge clock);
    for (int cyc = 0; cyc < NUM_ROWS + `EXEC_MUL_STAGES + 2; cyc++) begin
      @(posedge clock);
      #1;
      reset = 1'b0;
      if (cyc < NUM_ROWS) begin
        cur = rows[cyc];
      end else begin
        cur = '0;
      end
      alu_req = cur.alu;
      mul_req = cur.mul;
      ls_req  = cur.ls;
      br_req  = cur.br;
      if (cur.mul.valid) begin
        mul_q.push_back('{due: cyc + `EXEC_MUL_STAGES, resp: cur.exp_mul});
      end
      #5;
      check_wb("wb_o[0]", wb[0], cur.exp_alu);
      check_wb("wb_o[2]", wb[2], cur.exp_br);
      check_lsq(lsq, cur.exp_lsq);
      check_mul(cyc);
    end
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog covering reset, every row and the multiplier drain
  initial begin
    #((RESET_CYCLES + NUM_ROWS + `EXEC_MUL_STAGES + 20) * CLK_PERIOD);
    $display("Timeout: the run did not finish in time, checks %0d errors %0d", checks, errors);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+hw
hw/exec_pkg.sv
hw/alu_fu.sv
hw/mul_fu.sv
hw/ls_fu.sv
hw/branch_fu.sv
hw/exec_units.sv
bench/exec_units_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module exec_units_tb -f files.f -o exec_units_sim > build.log 2>&1 &&
./obj_dir/exec_units_sim > sim.log 2>&1 ||
echo "Build or simulation returned an error, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "Testbench passed" sim.log 2>/dev/null && echo "PASS" && exit 0
echo "FAIL"
exit 1
